// File: src/game_pkg.sv
package game_pkg;

   typedef logic signed [10:0] coord_t;
   typedef logic [6:0] step_t;

   typedef struct packed {
      coord_t x;
      coord_t y;
   } player_pos_t;

   typedef struct packed {
      coord_t car_x;
      coord_t truck_x;
      coord_t bigtruck_x;
   } traffic_pos_t;

   typedef enum logic [1:0] {
      MOVEMENT,
      WIN,
      LOSE
   } game_state_t;

   typedef struct packed {
      player_pos_t  player;
      traffic_pos_t traffic;
      game_state_t  state;
   } scene_t;

   typedef struct packed {
      logic up;
      logic left;
      logic right;
   } buttons_t;

   localparam coord_t GRID_STEP   = 80;
   localparam coord_t FIELD_MIN_X = 8;
   localparam coord_t FIELD_MAX_X = 568;
   localparam coord_t GOAL_ROW_Y  = 8;
   localparam coord_t START_X     = 88;
   localparam coord_t START_Y     = 408;

   localparam coord_t BIGTRUCK_ROW_Y = 88;
   localparam coord_t TRUCK_ROW_Y    = 248;
   localparam coord_t CAR_ROW_Y      = 328;

   localparam int BIGTRUCK_LEN    = 192;
   localparam int TRUCK_LEN       = 128;
   localparam int BIGTRUCK_GAP    = 400;
   localparam int TRUCK_GAP       = 240;
   localparam int CAR_GAP         = 240;
   localparam int BIGTRUCK_COPIES = 2;
   localparam int TRUCK_COPIES    = 3;
   localparam int CAR_COPIES      = 3;

   localparam coord_t GOAL_BRICK_X [5] = '{8, 168, 248, 408, 488};

   localparam coord_t CAR_SEQ      [3] = '{8, 88, 168};
   localparam coord_t TRUCK_SEQ    [3] = '{8, 88, -72};
   localparam coord_t BIGTRUCK_SEQ [5] = '{8, -72, -152, 168, 88};

   localparam step_t STEP_MAX = 99;

endpackage

// File: src/panel_pkg.sv
package panel_pkg;

   typedef logic [3:0] digit_t;

   typedef enum logic [1:0] {
      DIG_WIN_HI,
      DIG_WIN_LO,
      DIG_TENS,
      DIG_ONES
   } scan_digit_t;

   localparam logic [7:0] SEG_CODE [10] = '{
      8'h3f, 8'h06, 8'h5b, 8'h4f, 8'h66,
      8'h6d, 8'h7d, 8'h07, 8'h7f, 8'h6f
   };

   localparam digit_t WIN_DIGIT = 4'd9;

   // pairs of lamps moving from the middle to the edges
   localparam logic [15:0] CHASE [8] = '{
      16'h0180, 16'h0240, 16'h0420, 16'h0810,
      16'h1008, 16'h2004, 16'h4002, 16'h8001
   };

   localparam logic [27:0] DEF_DEBOUNCE = 28'd1048576;
   localparam logic [27:0] DEF_TRAFFIC  = 28'd134217728;
   localparam logic [27:0] DEF_SCAN     = 28'd262144;
   localparam logic [27:0] DEF_LIGHT    = 28'd33554432;

endpackage

// File: src/button_debouncer.sv
`timescale 1ns/100ps

module button_debouncer #(
   parameter int unsigned HOLD_CYCLES = 4
) (
   input  logic clk,
   input  logic reset,
   input  logic raw,
   output logic pressed
);

   logic [$clog2(HOLD_CYCLES + 1)-1:0] hold_count;

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         hold_count <= ($clog2(HOLD_CYCLES + 1))'(HOLD_CYCLES); // released after reset
      end else if (raw) begin
         hold_count <= '0;
      end else if (hold_count < HOLD_CYCLES) begin
         hold_count <= hold_count + 1'b1;
      end
   end

   // stretched until the contact stays open long enough
   assign pressed = (hold_count < HOLD_CYCLES);

endmodule

// File: src/tick_generator.sv
`timescale 1ns/100ps

module tick_generator #(
   parameter int unsigned PERIOD = 4
) (
   input  logic clk,
   input  logic reset,
   output logic tick
);

   logic [$clog2(PERIOD + 1)-1:0] count;

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         count <= '0;
      end else if (count == PERIOD - 1) begin
         count <= '0; // wrap
      end else begin
         count <= count + 1'b1;
      end
   end

   assign tick = (count == PERIOD - 1);

endmodule

// File: src/player_mover.sv
`timescale 1ns/100ps

module player_mover (
   input  logic                       clk,
   input  logic                       reset,
   input  game_pkg::buttons_t         buttons,
   input  game_pkg::game_state_t      state,
   output game_pkg::player_pos_t      pos,
   output game_pkg::step_t            step
);

   game_pkg::buttons_t    buttons_prev;
   game_pkg::buttons_t    rise;
   game_pkg::player_pos_t pos_next;
   logic                  moved;

   always_comb begin
      rise     = buttons & ~buttons_prev;
      pos_next = pos;
      moved    = 1'b0;
      if (rise.up) begin
         if (pos.y != game_pkg::GOAL_ROW_Y) begin
            pos_next.y = pos.y - game_pkg::GRID_STEP;
            moved      = 1'b1;
         end
      end else if (rise.left) begin
         if (pos.x != game_pkg::FIELD_MIN_X) begin
            pos_next.x = pos.x - game_pkg::GRID_STEP;
            moved      = 1'b1;
         end
      end else if (rise.right) begin
         if (pos.x != game_pkg::FIELD_MAX_X) begin
            pos_next.x = pos.x + game_pkg::GRID_STEP;
            moved      = 1'b1;
         end
      end
   end

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         buttons_prev <= '0;
         pos.x        <= game_pkg::START_X;
         pos.y        <= game_pkg::START_Y;
         step         <= '0;
      end else begin
         buttons_prev <= buttons; // edges tracked even while frozen
         if (state == game_pkg::MOVEMENT && moved) begin
            pos <= pos_next;
            if (step < game_pkg::STEP_MAX) begin
               step <= step + 7'd1;
            end
         end
      end
   end

endmodule

// File: src/traffic_mover.sv
`timescale 1ns/100ps

module traffic_mover (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    tick,
   input  game_pkg::game_state_t   state,
   output game_pkg::traffic_pos_t  traffic
);

   logic [1:0] car_idx;
   logic [1:0] truck_idx;
   logic [2:0] bigtruck_idx;
   logic       truck_phase;

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         car_idx      <= '0;
         truck_idx    <= '0;
         bigtruck_idx <= '0;
         truck_phase  <= 1'b0;
      end else if (tick && state == game_pkg::MOVEMENT) begin
         if (car_idx == 2'($size(game_pkg::CAR_SEQ) - 1)) begin
            car_idx <= '0;
         end else begin
            car_idx <= car_idx + 2'd1;
         end
         truck_phase <= ~truck_phase;
         if (truck_phase) begin // every second tick
            if (truck_idx == 2'($size(game_pkg::TRUCK_SEQ) - 1)) begin
               truck_idx <= '0;
            end else begin
               truck_idx <= truck_idx + 2'd1;
            end
            if (bigtruck_idx == 3'($size(game_pkg::BIGTRUCK_SEQ) - 1)) begin
               bigtruck_idx <= '0;
            end else begin
               bigtruck_idx <= bigtruck_idx + 3'd1;
            end
         end
      end
   end

   assign traffic.car_x      = game_pkg::CAR_SEQ[car_idx];
   assign traffic.truck_x    = game_pkg::TRUCK_SEQ[truck_idx];
   assign traffic.bigtruck_x = game_pkg::BIGTRUCK_SEQ[bigtruck_idx];

endmodule

// File: src/incident_detector.sv
`timescale 1ns/100ps

module incident_detector (
   input  logic                    clk,
   input  logic                    reset,
   input  game_pkg::player_pos_t   player,
   input  game_pkg::traffic_pos_t  traffic,
   output game_pkg::game_state_t   state
);

   game_pkg::game_state_t verdict;

   // true when px lies in one of the copies of a vehicle starting at vx
   function automatic logic in_span(game_pkg::coord_t px, game_pkg::coord_t vx,
                                    int copies, int gap, int len);
      int   lo;
      logic hit;
      hit = 1'b0;
      for (int k = 0; k < copies; k++) begin
         lo = int'(vx) + k * gap;
         if (int'(px) >= lo && int'(px) <= lo + len - 1) begin
            hit = 1'b1;
         end
      end
      return hit;
   endfunction

   always_comb begin
      verdict = game_pkg::MOVEMENT;
      if (player.y == game_pkg::GOAL_ROW_Y) begin
         verdict = game_pkg::WIN;
         foreach (game_pkg::GOAL_BRICK_X[i]) begin
            if (player.x == game_pkg::GOAL_BRICK_X[i]) begin
               verdict = game_pkg::LOSE; // jumped onto a brick
            end
         end
      end else if (player.y == game_pkg::BIGTRUCK_ROW_Y) begin
         if (in_span(player.x, traffic.bigtruck_x, game_pkg::BIGTRUCK_COPIES,
                     game_pkg::BIGTRUCK_GAP, game_pkg::BIGTRUCK_LEN)) begin
            verdict = game_pkg::LOSE;
         end
      end else if (player.y == game_pkg::TRUCK_ROW_Y) begin
         if (in_span(player.x, traffic.truck_x, game_pkg::TRUCK_COPIES,
                     game_pkg::TRUCK_GAP, game_pkg::TRUCK_LEN)) begin
            verdict = game_pkg::LOSE;
         end
      end else if (player.y == game_pkg::CAR_ROW_Y) begin
         // cars only hit on an exact grid match
         if (in_span(player.x, traffic.car_x, game_pkg::CAR_COPIES, game_pkg::CAR_GAP, 1)) begin
            verdict = game_pkg::LOSE;
         end
      end
   end

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         state <= game_pkg::MOVEMENT;
      end else if (state == game_pkg::MOVEMENT) begin
         state <= verdict; // win and lose stick
      end
   end

endmodule

// File: src/score_display.sv
`timescale 1ns/100ps

module score_display (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  tick,
   input  game_pkg::game_state_t state,
   input  game_pkg::step_t       step,
   output logic [3:0]            seg_enable,
   output logic [7:0]            sevenseg
);

   panel_pkg::scan_digit_t scan;
   panel_pkg::scan_digit_t scan_next;
   panel_pkg::digit_t      tens;
   panel_pkg::digit_t      ones;
   panel_pkg::digit_t      digit;
   logic [3:0]             enable_next;

   assign tens      = panel_pkg::digit_t'(step / 7'd10);
   assign ones      = panel_pkg::digit_t'(step % 7'd10);
   assign scan_next = tick ? panel_pkg::scan_digit_t'(scan + 2'd1) : scan;

   always_comb begin
      enable_next = 4'b0000;
      digit       = 4'd0;
      case (scan_next)
         panel_pkg::DIG_WIN_HI: begin
            if (state == game_pkg::WIN) begin
               enable_next = 4'b1000;
               digit       = panel_pkg::WIN_DIGIT;
            end
         end
         panel_pkg::DIG_WIN_LO: begin
            if (state == game_pkg::WIN) begin
               enable_next = 4'b0100;
               digit       = panel_pkg::WIN_DIGIT;
            end
         end
         panel_pkg::DIG_TENS: begin
            enable_next = 4'b0010;
            digit       = tens;
         end
         default: begin
            enable_next = 4'b0001; // ones digit
            digit       = ones;
         end
      endcase
   end

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         scan       <= panel_pkg::DIG_WIN_HI;
         seg_enable <= 4'b0000;
         sevenseg   <= panel_pkg::SEG_CODE[0];
      end else begin
         scan       <= scan_next;
         seg_enable <= enable_next;
         sevenseg   <= panel_pkg::SEG_CODE[digit]; // refreshed every clock
      end
   end

endmodule

// File: src/lose_lights.sv
`timescale 1ns/100ps

module lose_lights (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  tick,
   input  game_pkg::game_state_t state,
   output logic [15:0]           light
);

   logic [2:0] chase_idx;

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         chase_idx <= '0;
      end else if (state != game_pkg::LOSE) begin
         chase_idx <= '0;
      end else if (tick) begin
         chase_idx <= chase_idx + 3'd1; // wraps after the last pattern
      end
   end

   assign light = (state == game_pkg::LOSE) ? panel_pkg::CHASE[chase_idx] : 16'h0000;

endmodule

// File: src/frog_game_top.sv
`timescale 1ns/100ps

module frog_game_top #(
   parameter logic [27:0] DEBOUNCE       = panel_pkg::DEF_DEBOUNCE,
   parameter logic [27:0] TRAFFIC_PERIOD = panel_pkg::DEF_TRAFFIC,
   parameter logic [27:0] SCAN_PERIOD    = panel_pkg::DEF_SCAN,
   parameter logic [27:0] LIGHT_PERIOD   = panel_pkg::DEF_LIGHT
) (
   input  logic                clk,
   input  logic                reset,
   input  game_pkg::buttons_t  button,
   output game_pkg::scene_t    scene,
   output logic [7:0]          sevenseg,
   output logic [3:0]          seg_enable,
   output logic [15:0]         light
);

   game_pkg::buttons_t     button_clean;
   game_pkg::player_pos_t  player_pos;
   game_pkg::traffic_pos_t traffic_pos;
   game_pkg::game_state_t  state;
   game_pkg::step_t        step;
   logic                   traffic_tick;
   logic                   scan_tick;
   logic                   light_tick;

   button_debouncer #(.HOLD_CYCLES(DEBOUNCE)) up_debounce_i (
      .clk(clk), .reset(reset), .raw(button.up), .pressed(button_clean.up)
   );
   button_debouncer #(.HOLD_CYCLES(DEBOUNCE)) left_debounce_i (
      .clk(clk), .reset(reset), .raw(button.left), .pressed(button_clean.left)
   );
   button_debouncer #(.HOLD_CYCLES(DEBOUNCE)) right_debounce_i (
      .clk(clk), .reset(reset), .raw(button.right), .pressed(button_clean.right)
   );

   tick_generator #(.PERIOD(TRAFFIC_PERIOD)) traffic_tick_i (
      .clk(clk), .reset(reset), .tick(traffic_tick)
   );
   tick_generator #(.PERIOD(SCAN_PERIOD)) scan_tick_i (
      .clk(clk), .reset(reset), .tick(scan_tick)
   );
   tick_generator #(.PERIOD(LIGHT_PERIOD)) light_tick_i (
      .clk(clk), .reset(reset), .tick(light_tick)
   );

   player_mover player_i (
      .clk(clk), .reset(reset), .buttons(button_clean), .state(state),
      .pos(player_pos), .step(step)
   );

   traffic_mover traffic_i (
      .clk(clk), .reset(reset), .tick(traffic_tick), .state(state), .traffic(traffic_pos)
   );

   incident_detector detector_i (
      .clk(clk), .reset(reset), .player(player_pos), .traffic(traffic_pos), .state(state)
   );

   score_display display_i (
      .clk(clk), .reset(reset), .tick(scan_tick), .state(state), .step(step),
      .seg_enable(seg_enable), .sevenseg(sevenseg)
   );

   lose_lights lights_i (
      .clk(clk), .reset(reset), .tick(light_tick), .state(state), .light(light)
   );

   // handed to the external renderer
   assign scene.player  = player_pos;
   assign scene.traffic = traffic_pos;
   assign scene.state   = state;

endmodule

// File: verification/frog_game_cases.svh
`ifndef FROG_GAME_CASES_SVH
`define FROG_GAME_CASES_SVH

// press is {up, left, right}; 3'b000 applies a reset instead of a press
// count is the number of presses, pos/state/step are expected after the last one
typedef struct {
   string                 name;
   game_pkg::buttons_t    press;
   int                    count;
   game_pkg::player_pos_t pos;
   game_pkg::game_state_t state;
   game_pkg::step_t       step;
} move_case_t;

move_case_t cases [18] = '{
   '{"left to edge",      3'b010, 1, '{8, 408},   game_pkg::MOVEMENT, 1},
   '{"left blocked",      3'b010, 1, '{8, 408},   game_pkg::MOVEMENT, 1},
   '{"right from edge",   3'b001, 1, '{88, 408},  game_pkg::MOVEMENT, 2},
   '{"right to edge",     3'b001, 6, '{568, 408}, game_pkg::MOVEMENT, 8},
   '{"right blocked",     3'b001, 1, '{568, 408}, game_pkg::MOVEMENT, 8},
   '{"left back to 88",   3'b010, 6, '{88, 408},  game_pkg::MOVEMENT, 14},
   '{"car row clear",     3'b100, 1, '{88, 328},  game_pkg::MOVEMENT, 15},
   '{"car row right",     3'b001, 1, '{168, 328}, game_pkg::MOVEMENT, 16},
   '{"truck row gap",     3'b100, 1, '{168, 248}, game_pkg::MOVEMENT, 17},
   '{"open row",          3'b100, 1, '{168, 168}, game_pkg::MOVEMENT, 18},
   '{"long truck hit",    3'b100, 1, '{168, 88},  game_pkg::LOSE,     19},
   '{"frozen after lose", 3'b001, 1, '{168, 88},  game_pkg::LOSE,     19},
   '{"restart",           3'b000, 0, '{88, 408},  game_pkg::MOVEMENT, 0},
   '{"win path right",    3'b001, 1, '{168, 408}, game_pkg::MOVEMENT, 1},
   '{"win path up",       3'b100, 3, '{168, 168}, game_pkg::MOVEMENT, 4},
   '{"open row right",    3'b001, 2, '{328, 168}, game_pkg::MOVEMENT, 6},
   '{"long truck gap",    3'b100, 1, '{328, 88},  game_pkg::MOVEMENT, 7},
   '{"goal reached",      3'b100, 1, '{328, 8},   game_pkg::WIN,      8}
};

`endif

// File: verification/frog_game_tb.sv
`timescale 1ns/100ps

module frog_game_tb;

   logic               clk;
   logic               reset;
   game_pkg::buttons_t button;
   game_pkg::scene_t   scene;
   game_pkg::scene_t   fast_scene;
   logic [7:0]         sevenseg;
   logic [3:0]         seg_enable;
   logic [15:0]        light;
   logic               win_allowed;
   string              current_name;

   `include "frog_game_cases.svh"

   frog_game_top #(
      .DEBOUNCE(28'd4), .TRAFFIC_PERIOD(28'd200000), .SCAN_PERIOD(28'd3), .LIGHT_PERIOD(28'd5)
   ) dut_i (
      .clk(clk), .reset(reset), .button(button), .scene(scene),
      .sevenseg(sevenseg), .seg_enable(seg_enable), .light(light)
   );

   // second build with fast traffic and idle buttons that keep the player on the start row
   frog_game_top #(
      .DEBOUNCE(28'd4), .TRAFFIC_PERIOD(28'd6), .SCAN_PERIOD(28'd3), .LIGHT_PERIOD(28'd5)
   ) traffic_dut_i (
      .clk(clk), .reset(reset), .button(3'b000), .scene(fast_scene),
      .sevenseg(), .seg_enable(), .light()
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic stop_on_error(input string line);
      $display("%s", line);
      $display("sim failed");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic apply_reset();
      @(posedge clk);
      #1 reset = 1'b0;
      win_allowed = 1'b0;
      repeat (8) @(posedge clk);
      #1 reset = 1'b1;
      @(negedge clk);
   endtask

   task automatic press_button(input game_pkg::buttons_t b);
      int waited;
      @(posedge clk);
      #1 button = b;
      repeat (3) @(posedge clk);
      #1 button = 3'b000;
      waited = 0;
      while (dut_i.button_clean !== 3'b000 && waited < 50) begin
         @(negedge clk);
         waited++;
      end
      if (waited >= 50) stop_on_error("timeout: the debounced button never released");
      repeat (2) @(posedge clk); // edge detector sees the release
   endtask

   task automatic wait_enable(input panel_pkg::scan_digit_t d);
      int waited;
      waited = 0;
      while (seg_enable !== (4'b1000 >> d) && waited < 40) begin
         @(negedge clk);
         waited++;
      end
      if (waited >= 40) stop_on_error({"timeout: the display never enabled digit ", d.name()});
   endtask

   task automatic check_pos(input string name, input game_pkg::player_pos_t exp);
      if (scene.player !== exp) begin
         stop_on_error($sformatf("Error %s: expected pos (%0d,%0d) actual (%0d,%0d)",
                                 name, exp.x, exp.y, scene.player.x, scene.player.y));
      end
   endtask

   task automatic check_state(input string name, input game_pkg::game_state_t exp);
      game_pkg::game_state_t actual;
      actual = scene.state;
      if (actual !== exp) begin
         stop_on_error($sformatf("Error %s: expected state %s actual %s",
                                 name, exp.name(), actual.name()));
      end
   endtask

   task automatic check_digits(input string name, input logic left_pair,
                               input panel_pkg::digit_t tens, input panel_pkg::digit_t ones);
      wait_enable(left_pair ? panel_pkg::DIG_WIN_HI : panel_pkg::DIG_TENS);
      if (sevenseg !== panel_pkg::SEG_CODE[tens]) begin
         stop_on_error($sformatf("Error %s: expected high segments %h actual %h",
                                 name, panel_pkg::SEG_CODE[tens], sevenseg));
      end
      wait_enable(left_pair ? panel_pkg::DIG_WIN_LO : panel_pkg::DIG_ONES);
      if (sevenseg !== panel_pkg::SEG_CODE[ones]) begin
         stop_on_error($sformatf("Error %s: expected low segments %h actual %h",
                                 name, panel_pkg::SEG_CODE[ones], sevenseg));
      end
   endtask

   task automatic check_light(input string name, input logic [15:0] exp);
      if (light !== exp) begin
         stop_on_error($sformatf("Error %s: expected light %h actual %h", name, exp, light));
      end
   endtask

   task automatic check_traffic(input string name, input game_pkg::traffic_pos_t exp,
                                input game_pkg::traffic_pos_t actual);
      if (actual !== exp) begin
         stop_on_error($sformatf("Error %s: expected traffic %0d/%0d/%0d actual %0d/%0d/%0d",
                                 name, exp.car_x, exp.truck_x, exp.bigtruck_x,
                                 actual.car_x, actual.truck_x, actual.bigtruck_x));
      end
   endtask

   task automatic follow_chase(input string name, input int changes);
      int          idx;
      int          waited;
      logic [15:0] last;
      idx = -1;
      for (int i = 0; i < $size(panel_pkg::CHASE); i++) begin
         if (light === panel_pkg::CHASE[i]) idx = i;
      end
      if (idx < 0) stop_on_error($sformatf("Error %s: expected a chase pattern actual %h",
                                           name, light));
      repeat (changes) begin
         last = light;
         waited = 0;
         while (light === last && waited < 40) begin
            @(negedge clk);
            waited++;
         end
         if (waited >= 40) stop_on_error("timeout: the chase lights stopped moving");
         idx = (idx + 1) % $size(panel_pkg::CHASE);
         check_light(name, panel_pkg::CHASE[idx]);
      end
   endtask

   task automatic run_case(input move_case_t c);
      current_name = c.name;
      if (c.press == 3'b000) begin
         apply_reset();
      end else begin
         win_allowed = (c.state == game_pkg::WIN); // left digits only after the winning move
         repeat (c.count) press_button(c.press);
      end
      @(negedge clk);
      check_pos(c.name, c.pos);
      check_state(c.name, c.state);
      check_traffic(c.name, '{8, 8, 8}, scene.traffic); // slow traffic stays parked
      check_digits(c.name, 1'b0, panel_pkg::digit_t'(c.step / 10),
                   panel_pkg::digit_t'(c.step % 10));
      if (c.state == game_pkg::LOSE) follow_chase(c.name, 10);
      else check_light(c.name, 16'h0000);
      if (c.state == game_pkg::WIN) begin
         check_digits(c.name, 1'b1, panel_pkg::WIN_DIGIT, panel_pkg::WIN_DIGIT);
      end
   endtask

   task automatic run_traffic_phase();
      int                     car_i;
      int                     truck_i;
      int                     big_i;
      int                     waited;
      logic                   slow;
      game_pkg::traffic_pos_t last;
      game_pkg::traffic_pos_t exp;
      car_i = 0;
      truck_i = 0;
      big_i = 0;
      slow = 1'b0;
      current_name = "traffic sequence";
      check_traffic("traffic reset", '{8, 8, 8}, fast_scene.traffic);
      repeat (12) begin
         last = fast_scene.traffic;
         waited = 0;
         while (fast_scene.traffic === last && waited < 20) begin
            @(negedge clk);
            waited++;
         end
         if (waited >= 20) stop_on_error("timeout: the traffic stopped moving");
         car_i = (car_i + 1) % $size(game_pkg::CAR_SEQ);
         if (slow) begin // trucks move on every second car step
            truck_i = (truck_i + 1) % $size(game_pkg::TRUCK_SEQ);
            big_i = (big_i + 1) % $size(game_pkg::BIGTRUCK_SEQ);
         end
         slow = ~slow;
         exp.car_x = game_pkg::CAR_SEQ[car_i];
         exp.truck_x = game_pkg::TRUCK_SEQ[truck_i];
         exp.bigtruck_x = game_pkg::BIGTRUCK_SEQ[big_i];
         check_traffic(current_name, exp, fast_scene.traffic);
      end
   endtask

   // left digit pair must stay dark until the winning move
   always @(negedge clk) begin
      if (reset && !win_allowed && seg_enable[3:2] != 2'b00) begin
         stop_on_error($sformatf("Error %s: expected no win digit enable actual %b",
                                 current_name, seg_enable));
      end
   end

   initial begin
      reset = 1'b0;
      button = 3'b000;
      win_allowed = 1'b0;
      current_name = "power on";
      apply_reset();
      foreach (cases[i]) begin
         run_case(cases[i]);
      end
      apply_reset();
      run_traffic_phase();
      $display("sim passed");
      $finish;
   end

endmodule

// File: filelist.f
+incdir+verification
src/game_pkg.sv
src/panel_pkg.sv
src/button_debouncer.sv
src/tick_generator.sv
src/player_mover.sv
src/traffic_mover.sv
src/incident_detector.sv
src/score_display.sv
src/lose_lights.sv
src/frog_game_top.sv
verification/frog_game_tb.sv

// File: Bender.yml
package:
  name: frog_game

sources:
  - src/game_pkg.sv
  - src/panel_pkg.sv
  - src/button_debouncer.sv
  - src/tick_generator.sv
  - src/player_mover.sv
  - src/traffic_mover.sv
  - src/incident_detector.sv
  - src/score_display.sv
  - src/lose_lights.sv
  - src/frog_game_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/frog_game_tb.sv
